// ==== hw/accel_defines.svh ====
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// grid geometry, rows = columns
`define ARRAY_DIM 2
`define COL_IDX_W $clog2(`ARRAY_DIM)

// operand words
`define OPND_W  25  // multiplier A port, one packed operand word
`define MUL_B_W 18  // multiplier B port, low part of an operand word
`define PIX_W   8   // signed pixel / weight

// accumulator lanes
`define ACC88_W    24  // mode 0, two lanes
`define ACC18_W    16  // mode 1, four lanes
`define CELL_OUT_W 64

// run length in operand steps
`define LEN_W 8

`endif

// ==== hw/accel_pkg.sv ====
`default_nettype none

`include "accel_defines.svh"

package accel_pkg;

  // values above mode_8x1 freeze the accumulators
  typedef enum logic [3:0] {
    mode_8x8 = 4'd0,
    mode_8x1 = 4'd1
  } calc_mode_e;

  // arithmetic packing, low field sign-extended into the high one
  //   mode 0  col feed = pixel0 + pixel1 * 2**16, row feed = weight
  //   mode 1  row feed = pixel0 + pixel1 * 2**18, col feed = weight0 + weight1 * 2**9
  // mode 1 pixel1 only has the 7 bits left above bit 18 of the 25-bit word
  typedef logic [`OPND_W-1:0] operand_t;

  typedef operand_t [`ARRAY_DIM-1:0] feed_vec_t;  // one word per row or column

  typedef logic [`CELL_OUT_W-1:0] cell_out_t;

  typedef cell_out_t [`ARRAY_DIM-1:0] col_out_t;  // indexed by row

  typedef struct packed {
    logic [`COL_IDX_W-1:0] col;
    col_out_t              row_out;
  } result_beat_t;

  typedef enum logic [1:0] {
    phase_idle,
    phase_compute,
    phase_drain
  } seq_phase_e;

endpackage

`default_nettype wire

// ==== hw/core_cell.sv ====
`default_nettype none

`include "accel_defines.svh"

module core_cell (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  en,
  input  wire logic                  cell_out_en,
  input  wire accel_pkg::calc_mode_e mode,
  input  wire accel_pkg::operand_t   left,
  input  wire accel_pkg::operand_t   up,
  input  wire accel_pkg::cell_out_t  next_cell_out,
  output accel_pkg::operand_t        right,
  output accel_pkg::operand_t        bottom,
  output accel_pkg::cell_out_t       out
);
  import accel_pkg::*;

  localparam int PROD_W = `OPND_W + `MUL_B_W;
  localparam int L88    = `ACC88_W;
  localparam int L18    = `ACC18_W;
  localparam int N88    = 2;  // mode 0 lanes
  localparam int N18    = `CELL_OUT_W / `ACC18_W;
  localparam int F88    = 16; // product field per mode 0 lane
  localparam int F18    = 9;  // product field per mode 1 lane

  logic signed [`OPND_W-1:0]  mul_a;
  logic signed [`MUL_B_W-1:0] mul_b;
  logic signed [PROD_W-1:0]   prod_q;

  logic [N88-1:0][L88-1:0] sum88;
  logic [N18-1:0][L18-1:0] sum18;

  // operand forwarding to the right and lower neighbours
  always_ff @(posedge clk) begin
    if (reset) begin
      right  <= '0;
      bottom <= '0;
    end else if (en) begin
      right  <= left;
      bottom <= up;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // packed multiply

  always_comb begin
    if (mode == mode_8x8) begin
      mul_a = up;  // two pixels
      mul_b = {{(`MUL_B_W - `PIX_W){left[`PIX_W-1]}}, left[`PIX_W-1:0]};
    end else begin
      mul_a = left;
      mul_b = up[`MUL_B_W-1:0];  // two binary weights
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
    end else if (en) begin
      prod_q <= mul_a * mul_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // field split and lane sums
  // a negative lower field borrowed one from the field above it

  for (genvar l = 0; l < N88; l++) begin : g_lane88
    logic [L88-1:0] field;
    logic           borrow;

    assign field = {{(L88 - F88){prod_q[l*F88 + F88 - 1]}}, prod_q[l*F88 +: F88]};
    if (l == 0) begin : g_first
      assign borrow = 1'b0;
    end else begin : g_rest
      assign borrow = prod_q[l*F88 - 1];
    end
    assign sum88[l] = out[l*L88 +: L88] + field + L88'(borrow);
  end

  for (genvar l = 0; l < N18; l++) begin : g_lane18
    logic [L18-1:0] field;
    logic           borrow;

    assign field = {{(L18 - F18){prod_q[l*F18 + F18 - 1]}}, prod_q[l*F18 +: F18]};
    if (l == 0) begin : g_first
      assign borrow = 1'b0;
    end else begin : g_rest
      assign borrow = prod_q[l*F18 - 1];
    end
    assign sum18[l] = out[l*L18 +: L18] + field + L18'(borrow);
  end

  // accumulate while computing, shift toward column 0 while draining
  always_ff @(posedge clk) begin
    if (reset) begin
      out <= '0;
    end else if (en) begin
      case (mode)
        mode_8x8: out[N88*L88-1:0] <= sum88;  // top 16 bits untouched
        mode_8x1: out <= sum18;
        default:  out <= out;
      endcase
    end else if (cell_out_en) begin
      out <= next_cell_out;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_skew.sv ====
`default_nettype none

`include "accel_defines.svh"

module operand_skew (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 en,
  input  wire accel_pkg::feed_vec_t row_feed,
  input  wire accel_pkg::feed_vec_t col_feed,
  output accel_pkg::feed_vec_t      row_skewed,
  output accel_pkg::feed_vec_t      col_skewed
);
  import accel_pkg::*;

  feed_vec_t row_in_q;
  feed_vec_t col_in_q;

  // first operands come with start, a cycle before en rises,
  // so the input stage samples every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      row_in_q <= '0;
      col_in_q <= '0;
    end else begin
      row_in_q <= row_feed;
      col_in_q <= col_feed;
    end
  end

  // lane i gets i more stages so step k meets cell (i,j) at k+i+j
  for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign row_skewed[0] = row_in_q[0];
      assign col_skewed[0] = col_in_q[0];
    end else begin : g_delay
      operand_t row_dly [i];
      operand_t col_dly [i];

      always_ff @(posedge clk) begin
        if (reset) begin
          for (int s = 0; s < i; s++) begin
            row_dly[s] <= '0;
            col_dly[s] <= '0;
          end
        end else if (en) begin
          row_dly[0] <= row_in_q[i];
          col_dly[0] <= col_in_q[i];
          for (int s = 1; s < i; s++) begin
            row_dly[s] <= row_dly[s-1];
            col_dly[s] <= col_dly[s-1];
          end
        end
      end

      assign row_skewed[i] = row_dly[i-1];
      assign col_skewed[i] = col_dly[i-1];
    end
  end

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
`default_nettype none

`include "accel_defines.svh"

module systolic_array (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  en,
  input  wire logic                  cell_out_en,
  input  wire accel_pkg::calc_mode_e mode,
  input  wire accel_pkg::feed_vec_t  row_in,
  input  wire accel_pkg::feed_vec_t  col_in,
  output accel_pkg::col_out_t        col0_out
);
  import accel_pkg::*;

  // h_bus[i][j] is the left input of cell (i,j), column ARRAY_DIM is the right edge
  operand_t  h_bus [`ARRAY_DIM][`ARRAY_DIM+1];
  // v_bus[i][j] is the up input of cell (i,j), row ARRAY_DIM is the bottom edge
  operand_t  v_bus [`ARRAY_DIM+1][`ARRAY_DIM];

  cell_out_t cell_res [`ARRAY_DIM][`ARRAY_DIM];
  cell_out_t shift_in [`ARRAY_DIM][`ARRAY_DIM];  // neighbour chain toward column 0

  //////////////////////////////////////////////////////////////////////
  // array edges

  for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_edge
    assign h_bus[i][0] = row_in[i];
    assign v_bus[0][i] = col_in[i];
    assign col0_out[i] = cell_res[i][0];  // drain exits at column 0
  end

  //////////////////////////////////////////////////////////////////////
  // cell grid

  for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_row
    for (genvar j = 0; j < `ARRAY_DIM; j++) begin : g_col
      if (j == `ARRAY_DIM - 1) begin : g_far
        assign shift_in[i][j] = '0;  // zeros clear the grid on drain
      end else begin : g_link
        assign shift_in[i][j] = cell_res[i][j+1];
      end

      core_cell i_cell (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .cell_out_en  (cell_out_en),
        .mode         (mode),
        .left         (h_bus[i][j]),
        .up           (v_bus[i][j]),
        .next_cell_out(shift_in[i][j]),
        .right        (h_bus[i][j+1]),
        .bottom       (v_bus[i+1][j]),
        .out          (cell_res[i][j])
      );
    end
  end

endmodule

`default_nettype wire

// ==== hw/array_sequencer.sv ====
`default_nettype none

`include "accel_defines.svh"

module array_sequencer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 start,
  input  wire logic [`LEN_W-1:0]    k_len,
  input  wire accel_pkg::col_out_t  col0_out,
  output logic                      en,
  output logic                      cell_out_en,
  output logic                      busy,
  output logic                      result_valid,
  output accel_pkg::result_beat_t   result,
  output logic                      done
);
  import accel_pkg::*;

  localparam int CNT_W = `LEN_W + 1;  // room for k_len + 2*ARRAY_DIM

  localparam logic [CNT_W-1:0] FILL_STEPS = CNT_W'(2 * `ARRAY_DIM - 2);
  localparam logic [CNT_W-1:0] LAST_COL   = CNT_W'(`ARRAY_DIM - 1);

  seq_phase_e       phase;
  logic [CNT_W-1:0] cnt;           // counts down in compute, up in drain
  logic [CNT_W-1:0] window_last;

  // k_len operand steps, plus skew fill and multiply latency
  assign window_last = {1'b0, k_len} + FILL_STEPS;

  assign en          = (phase == phase_compute);
  assign cell_out_en = (phase == phase_drain);
  assign busy        = (phase != phase_idle);

  //////////////////////////////////////////////////////////////////////
  // run phases

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phase_idle;
      cnt   <= '0;
    end else begin
      case (phase)
        phase_idle: begin
          if (start) begin  // only seen when idle
            phase <= phase_compute;
            cnt   <= window_last;
          end
        end
        phase_compute: begin
          if (cnt == '0) begin
            phase <= phase_drain;
            cnt   <= '0;  // column index from here on
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        phase_drain: begin
          if (cnt == LAST_COL) begin
            phase <= phase_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: phase <= phase_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result beats, one cycle behind each drain shift

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      done         <= 1'b0;
    end else begin
      result_valid <= cell_out_en;
      done         <= cell_out_en && (cnt == LAST_COL);  // with the last beat
    end
  end

  always_ff @(posedge clk) begin
    if (cell_out_en) begin
      result.col     <= cnt[`COL_IDX_W-1:0];
      result.row_out <= col0_out;  // value before this cycle's shift
    end
  end

endmodule

`default_nettype wire

// ==== hw/accel_top.sv ====
`default_nettype none

`include "accel_defines.svh"

module accel_top (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  start,
  input  wire logic [`LEN_W-1:0]     k_len,
  input  wire accel_pkg::calc_mode_e mode,
  input  wire accel_pkg::feed_vec_t  row_feed,
  input  wire accel_pkg::feed_vec_t  col_feed,
  output logic                       busy,
  output logic                       result_valid,
  output accel_pkg::result_beat_t    result,
  output logic                       done
);
  import accel_pkg::*;

  logic      en;
  logic      cell_out_en;
  feed_vec_t row_skewed;
  feed_vec_t col_skewed;
  col_out_t  col0_out;

  operand_skew i_skew (
    .clk       (clk),
    .reset     (reset),
    .en        (en),
    .row_feed  (row_feed),
    .col_feed  (col_feed),
    .row_skewed(row_skewed),
    .col_skewed(col_skewed)
  );

  systolic_array i_array (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .cell_out_en(cell_out_en),
    .mode       (mode),
    .row_in     (row_skewed),
    .col_in     (col_skewed),
    .col0_out   (col0_out)
  );

  array_sequencer i_seq (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .k_len       (k_len),
    .col0_out    (col0_out),
    .en          (en),
    .cell_out_en (cell_out_en),
    .busy        (busy),
    .result_valid(result_valid),
    .result      (result),
    .done        (done)
  );

endmodule

`default_nettype wire

// ==== verification/accel_checker.sv ====
`default_nettype none

`include "accel_defines.svh"

module accel_checker (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 start,
  input  wire logic [`LEN_W-1:0]                    k_len,
  input  wire logic                                 busy,
  input  wire logic                                 result_valid,
  input  wire accel_pkg::result_beat_t              result,
  input  wire logic                                 done,
  input  wire accel_pkg::col_out_t [`ARRAY_DIM-1:0] exp_cols,  // [col][row]
  input  wire logic                                 test_end,
  input  wire logic [7:0]                           test_num,
  input  wire logic [7:0]                           test_runs,
  output int                                        error_count,
  output int                                        beat_count,
  output int                                        test_count
);
  import accel_pkg::*;

  typedef logic [`COL_IDX_W-1:0] col_idx_t;

  int       test_beats;
  int       test_dones;
  int       test_errors;
  int       lat_cnt;      // cycles since the accepted start
  int       run_k;
  int       busy_left;    // busy cycles still due in this run
  logic     exp_busy;
  logic     lat_armed;
  col_idx_t exp_col;

  always @(posedge clk) begin
    if (reset) begin
      error_count = 0;
      beat_count  = 0;
      test_count  = 0;
      test_beats  = 0;
      test_dones  = 0;
      test_errors = 0;
      lat_cnt     = 0;
      run_k       = 0;
      busy_left   = 0;
      exp_busy    = 1'b0;
      lat_armed   = 1'b0;
      exp_col     = '0;
    end else begin
      exp_busy = (busy_left > 0);
      if (busy !== exp_busy) begin
        $display("FAILED busy expected %h actual %h", exp_busy, busy);
        test_errors++;
      end

      if (start && !exp_busy) begin  // a start during a run is dropped
        lat_armed = 1'b1;
        lat_cnt   = 0;
        run_k     = int'(k_len);
        busy_left = run_k + 3 * `ARRAY_DIM - 1;  // compute window plus drain
      end else begin
        if (lat_armed) begin
          lat_cnt++;
        end
        if (busy_left > 0) begin
          busy_left--;
        end
      end

      //////////////////////////////////////////////////////////////////////
      // result beats

      if (result_valid) begin
        exp_col = col_idx_t'(test_beats % `ARRAY_DIM);
        if (lat_armed) begin
          if (lat_cnt != run_k + 2 * `ARRAY_DIM + 1) begin
            $display("first result beat came %0d cycles after start, expected %0d",
                     lat_cnt, run_k + 2 * `ARRAY_DIM + 1);
            test_errors++;
          end
          lat_armed = 1'b0;
        end
        if (result.col !== exp_col) begin
          $display("FAILED result.col expected %h actual %h", exp_col, result.col);
          test_errors++;
        end
        for (int i = 0; i < `ARRAY_DIM; i++) begin
          if (result.row_out[i] !== exp_cols[exp_col][i]) begin
            $display("FAILED result.row_out[%0d] column %0d expected %h actual %h",
                     i, exp_col, exp_cols[exp_col][i], result.row_out[i]);
            test_errors++;
          end
        end
        test_beats++;
      end

      if (done) begin
        test_dones++;
        if (!result_valid || exp_col != col_idx_t'(`ARRAY_DIM - 1)) begin
          $display("done pulsed without the last result beat of a run");
          test_errors++;
        end
      end

      //////////////////////////////////////////////////////////////////////
      // per test summary

      if (test_end) begin
        if (test_beats != `ARRAY_DIM * int'(test_runs)) begin
          $display("test %0d expected %0d result beats but saw %0d",
                   test_num, `ARRAY_DIM * int'(test_runs), test_beats);
          test_errors++;
        end
        if (test_dones != int'(test_runs)) begin
          $display("test %0d expected %0d done pulses but saw %0d",
                   test_num, test_runs, test_dones);
          test_errors++;
        end
        $display("test %0d %s: %0d beats, %0d errors", test_num,
                 (test_errors == 0) ? "ok" : "bad", test_beats, test_errors);
        error_count += test_errors;
        beat_count  += test_beats;
        test_count++;
        test_beats  = 0;
        test_dones  = 0;
        test_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_accel.sv ====
`default_nettype none

`include "accel_defines.svh"

module tb_accel;
  import accel_pkg::*;

  localparam int MAX_K  = 16;
  localparam int N_RUNS = 7;
  localparam int RUN_K [N_RUNS] = '{3, 16, 16, 5, 7, 4, 6};

  logic         clk;
  logic         reset;
  logic         start;
  logic [`LEN_W-1:0] k_len;
  calc_mode_e   mode;
  feed_vec_t    row_feed;
  feed_vec_t    col_feed;
  logic         busy;
  logic         result_valid;
  result_beat_t result;
  logic         done;

  col_out_t [`ARRAY_DIM-1:0] exp_cols;
  logic         test_end;
  logic [7:0]   test_num;
  logic [7:0]   test_runs;
  int           error_count;
  int           beat_count;
  int           test_count;

  int seed;
  int cycle_count = 0;
  int cycle_limit;

  // operand fields per step, row side and column side
  //   mode 0  row a = weight, col a/b = pixel0/pixel1
  //   mode 1  row a/b = pixel0/pixel1, col a/b = weight0/weight1
  int row_a [MAX_K][`ARRAY_DIM];
  int row_b [MAX_K][`ARRAY_DIM];
  int col_a [MAX_K][`ARRAY_DIM];
  int col_b [MAX_K][`ARRAY_DIM];

  accel_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .k_len       (k_len),
    .mode        (mode),
    .row_feed    (row_feed),
    .col_feed    (col_feed),
    .busy        (busy),
    .result_valid(result_valid),
    .result      (result),
    .done        (done)
  );

  accel_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .k_len       (k_len),
    .busy        (busy),
    .result_valid(result_valid),
    .result      (result),
    .done        (done),
    .exp_cols    (exp_cols),
    .test_end    (test_end),
    .test_num    (test_num),
    .test_runs   (test_runs),
    .error_count (error_count),
    .beat_count  (beat_count),
    .test_count  (test_count)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped producing results", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model

  function automatic cell_out_t ref_cell(input calc_mode_e m, input int k,
                                         input int i, input int j);
    int        s0;
    int        s1;
    int        s2;
    int        s3;
    cell_out_t r;
    s0 = 0;
    s1 = 0;
    s2 = 0;
    s3 = 0;
    for (int s = 0; s < k; s++) begin
      s0 += row_a[s][i] * col_a[s][j];
      s1 += row_a[s][i] * col_b[s][j];
      s2 += row_b[s][i] * col_a[s][j];
      s3 += row_b[s][i] * col_b[s][j];
    end
    r = '0;  // mode 0 leaves the top 16 bits at zero
    if (m == mode_8x8) begin
      r[0 +: `ACC88_W]        = s0[`ACC88_W-1:0];
      r[`ACC88_W +: `ACC88_W] = s1[`ACC88_W-1:0];
    end else begin
      r[0 +: `ACC18_W]            = s0[`ACC18_W-1:0];
      r[`ACC18_W +: `ACC18_W]     = s1[`ACC18_W-1:0];
      r[2 * `ACC18_W +: `ACC18_W] = s2[`ACC18_W-1:0];
      r[3 * `ACC18_W +: `ACC18_W] = s3[`ACC18_W-1:0];
    end
    return r;
  endfunction

  function automatic operand_t row_word(input calc_mode_e m, input int a, input int b);
    if (m == mode_8x8) begin
      return operand_t'(a);
    end
    return operand_t'(a + b * 262144);  // pixel1 at bit 18
  endfunction

  function automatic operand_t col_word(input calc_mode_e m, input int a, input int b);
    if (m == mode_8x8) begin
      return operand_t'(a + b * 65536);  // pixel1 at bit 16
    end
    return operand_t'(a + b * 512);
  endfunction

  function automatic int run_budget();
    int total;
    total = 0;
    for (int r = 0; r < N_RUNS; r++) begin
      total += RUN_K[r] + 3 * `ARRAY_DIM + 10;
    end
    return total;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus

  task automatic fill_directed(input int k);
    for (int s = 0; s < k; s++) begin
      for (int n = 0; n < `ARRAY_DIM; n++) begin
        row_a[s][n] = n + s + 1;
        row_b[s][n] = 0;
        col_a[s][n] = 2 * s + n + 1;
        col_b[s][n] = 3 + s + 2 * n;
      end
    end
  endtask

  task automatic fill_random(input calc_mode_e m, input int k);
    logic signed [7:0] b8;
    logic signed [6:0] b7;
    for (int s = 0; s < k; s++) begin
      for (int n = 0; n < `ARRAY_DIM; n++) begin
        b8 = 8'($random(seed));
        row_a[s][n] = int'(b8);
        if (m == mode_8x8) begin
          row_b[s][n] = 0;
          b8 = 8'($random(seed));
          col_a[s][n] = int'(b8);
          b8 = 8'($random(seed));
          col_b[s][n] = int'(b8);
        end else begin
          b7 = 7'($random(seed));  // only 7 bits above bit 18
          row_b[s][n] = int'(b7);
          col_a[s][n] = $random(seed) & 1;
          col_b[s][n] = $random(seed) & 1;
        end
      end
    end
  endtask

  // called on a rising edge, returns on the edge where done is seen
  task automatic run_once(input calc_mode_e m, input int k, input logic poke_busy);
    col_out_t [`ARRAY_DIM-1:0] ecols;
    feed_vec_t rv;
    feed_vec_t cv;
    for (int j = 0; j < `ARRAY_DIM; j++) begin
      for (int i = 0; i < `ARRAY_DIM; i++) begin
        ecols[j][i] = ref_cell(m, k, i, j);
      end
    end
    exp_cols <= ecols;
    mode     <= m;
    k_len    <= `LEN_W'(k);
    for (int s = 0; s < k; s++) begin
      for (int n = 0; n < `ARRAY_DIM; n++) begin
        rv[n] = row_word(m, row_a[s][n], row_b[s][n]);
        cv[n] = col_word(m, col_a[s][n], col_b[s][n]);
      end
      start    <= (s == 0);
      row_feed <= rv;
      col_feed <= cv;
      @(posedge clk);
    end
    start    <= 1'b0;
    row_feed <= '0;
    col_feed <= '0;
    if (poke_busy) begin
      @(posedge clk);
      start <= 1'b1;  // still computing, should be ignored
      k_len <= `LEN_W'(2);
      @(posedge clk);
      start <= 1'b0;
      k_len <= `LEN_W'(k);
    end
    while (!done) @(posedge clk);
  endtask

  task automatic close_test(input int num, input int runs, input int settle);
    repeat (settle) @(posedge clk);
    test_num  <= 8'(num);
    test_runs <= 8'(runs);
    test_end  <= 1'b1;
    @(posedge clk);
    test_end  <= 1'b0;
  endtask

  initial begin
    seed        = 75263;
    cycle_limit = run_budget();
    clk         = 1'b0;
    reset       <= 1'b1;
    start       <= 1'b0;
    k_len       <= '0;
    mode        <= mode_8x8;
    row_feed    <= '0;
    col_feed    <= '0;
    exp_cols    <= '0;
    test_end    <= 1'b0;
    test_num    <= '0;
    test_runs   <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    fill_directed(RUN_K[0]);
    run_once(mode_8x8, RUN_K[0], 1'b0);
    close_test(1, 1, 2);

    fill_random(mode_8x8, RUN_K[1]);  // full range, exercises the borrows
    run_once(mode_8x8, RUN_K[1], 1'b0);
    close_test(2, 1, 2);

    fill_random(mode_8x1, RUN_K[2]);
    run_once(mode_8x1, RUN_K[2], 1'b0);
    close_test(3, 1, 2);

    // back to back, modes alternate
    fill_random(mode_8x8, RUN_K[3]);
    run_once(mode_8x8, RUN_K[3], 1'b0);
    fill_random(mode_8x1, RUN_K[4]);
    run_once(mode_8x1, RUN_K[4], 1'b0);
    fill_random(mode_8x8, RUN_K[5]);
    run_once(mode_8x8, RUN_K[5], 1'b0);
    close_test(4, 3, 2);

    fill_random(mode_8x1, RUN_K[6]);
    run_once(mode_8x1, RUN_K[6], 1'b1);
    close_test(5, 1, 12);  // long settle to catch stray beats

    @(negedge clk);
    $display("%0d tests, %0d beats, %0d errors", test_count, beat_count, error_count);
    if (error_count == 0 && test_count == 5) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/accel_pkg.sv
hw/core_cell.sv
hw/operand_skew.sv
hw/systolic_array.sv
hw/array_sequencer.sv
hw/accel_top.sv
verification/accel_checker.sv
verification/tb_accel.sv

// ==== Makefile ====
# Verilator build and run for the systolic MAC array testbench

VERILATOR ?= verilator
TOP       ?= tb_accel
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard hw/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
